//--- loong_csr.f
+incdir+logic
logic/csr_pkg.sv
logic/csr_decode.sv
logic/csr_exc_state.sv
logic/csr_timer.sv
logic/csr_save_bank.sv
logic/loong_csr.sv
tests/csr_tb.sv

//--- tests/csr_tb.sv
`include "csr_macros.svh"

module csr_tb import csr_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    // Directed sequence needs well under 250 cycles
    localparam int MAX_CYCLES = 600;

    logic        clk;
    logic        reset;
    csr_access_t access;
    exc_report_t exc;
    logic [31:0] rdata, ex_entry, ertn_entry;
    logic        has_int;

    // Reference model, kept as whole register words
    logic [31:0] m_crmd, m_prmd, m_estat, m_era, m_badv, m_eentry, m_ecfg;
    logic [31:0] m_tcfg, m_cnt;
    logic [31:0] m_save [4];
    logic        m_pend;
    logic [31:0] exp_estat, exp_rdata;
    logic        exp_has_int;
    int          err_cnt [4] = '{0, 0, 0, 0};
    int          cycles;

    loong_csr u_loong_csr (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] masked(input logic [31:0] old, input logic [31:0] mask,
                                           input logic [31:0] value);
        return (old & ~mask) | (value & mask);
    endfunction

    always_comb begin
        exp_estat = m_estat | {20'b0, m_pend, 11'b0};
        case (access.num)
            `CSR_CRMD:   exp_rdata = m_crmd;
            `CSR_PRMD:   exp_rdata = m_prmd;
            `CSR_ESTAT:  exp_rdata = exp_estat;
            `CSR_ERA:    exp_rdata = m_era;
            `CSR_BADV:   exp_rdata = m_badv;
            `CSR_EENTRY: exp_rdata = m_eentry;
            `CSR_ECFG:   exp_rdata = m_ecfg;
            `CSR_TCFG:   exp_rdata = m_tcfg;
            `CSR_TVAL:   exp_rdata = m_cnt;
            `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3:
                exp_rdata = m_save[access.num - `CSR_SAVE0];
            // TICLR and unmapped numbers
            default:     exp_rdata = 32'b0;
        endcase
        exp_has_int = |(exp_estat[11:0] & m_ecfg[11:0]) && m_crmd[`CRMD_IE];
    end

    // Model steps on the same edge as the DUT
    always @(posedge clk) begin
        logic [31:0] merged;
        logic        clr;
        merged = masked(exp_rdata, access.wmask, access.wvalue);
        clr    = access.we && access.num == `CSR_TICLR && access.wmask[0] && access.wvalue[0];
        if (reset) begin
            m_crmd  <= 32'b0;
            m_estat <= 32'b0;
            m_ecfg  <= 32'b0;
            m_tcfg  <= 32'b0;
            m_cnt   <= '1;
            m_pend  <= 1'b0;
            // Offset bits of EENTRY read zero even before the first write
            m_eentry <= m_eentry & 32'hffff_ffc0;
        end else begin
            if (access.we) begin
                case (access.num)
                    `CSR_CRMD:   m_crmd   <= merged & 32'h7;
                    `CSR_PRMD:   m_prmd   <= merged & 32'h7;
                    `CSR_ESTAT:  m_estat  <= {m_estat[31:2], merged[1:0]};
                    `CSR_ERA:    m_era    <= merged;
                    `CSR_BADV:   m_badv   <= merged;
                    `CSR_EENTRY: m_eentry <= merged & 32'hffff_ffc0;
                    `CSR_ECFG:   m_ecfg   <= merged & 32'h1fff;
                    `CSR_TCFG:   m_tcfg   <= merged;
                    `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3:
                        m_save[access.num - `CSR_SAVE0] <= merged;
                    default: ;
                endcase
            end
            // Initval scaled by four, one-shot wraps to all ones
            if (access.we && access.num == `CSR_TCFG && merged[`TCFG_EN]) begin
                m_cnt <= merged & ~32'h3;
            end else if (m_tcfg[`TCFG_EN] && m_cnt != '1) begin
                m_cnt <= (m_cnt == 32'b0 && m_tcfg[`TCFG_PERIODIC]) ? m_tcfg & ~32'h3 : m_cnt - 1;
            end
            if (m_tcfg[`TCFG_EN] && m_cnt == 32'b0) begin
                m_pend <= 1'b1;
            end else if (clr) begin
                m_pend <= 1'b0;
            end
            // Later assignments win over a CSR write on the same edge
            if (exc.ex) begin
                m_crmd  <= 32'b0;
                m_prmd  <= m_crmd;
                m_era   <= exc.pc;
                m_estat <= {1'b0, exc.esubcode, exc.ecode, 14'b0, m_estat[1:0]};
                if (exc.ecode == `ECODE_ADE && exc.esubcode == `ESUBCODE_ADEF) begin
                    m_badv <= exc.pc;
                end else if (exc.ecode == `ECODE_ADE || exc.ecode == `ECODE_ALE) begin
                    m_badv <= exc.vaddr;
                end
            end else if (exc.ertn) begin
                m_crmd <= m_prmd;
            end
        end
    end

    a_rdata: assert property (@(posedge clk) disable iff (reset) rdata === exp_rdata)
        else flag_mismatch(0, "rdata differs from model");
    a_ex_entry: assert property (@(posedge clk) disable iff (reset) ex_entry === m_eentry)
        else flag_mismatch(1, "ex_entry differs from EENTRY");
    a_ertn_entry: assert property (@(posedge clk) disable iff (reset) ertn_entry === m_era)
        else flag_mismatch(2, "ertn_entry differs from ERA");
    a_has_int: assert property (@(posedge clk) disable iff (reset) has_int === exp_has_int)
        else flag_mismatch(3, "has_int differs from model");

    task automatic flag_mismatch(input int idx, input string what);
        err_cnt[idx]++;
        $display("CHECK FAILED at %0t: %s, csr 0x%03h", $time, what, access.num);
    endtask

    task automatic csr_write(input logic [13:0] num, input logic [31:0] mask,
                             input logic [31:0] value);
        access.we     = 1'b1;
        access.num    = num;
        access.wmask  = mask;
        access.wvalue = value;
        @(negedge clk);
        access.we = 1'b0;
    endtask

    task automatic csr_read(input logic [13:0] num);
        access.num = num;
        @(negedge clk);
    endtask

    task automatic raise_exception(input logic [31:0] pc, input logic [5:0] ecode,
                                   input logic [8:0] esubcode, input logic [31:0] vaddr);
        exc.ex       = 1'b1;
        exc.pc       = pc;
        exc.ecode    = ecode;
        exc.esubcode = esubcode;
        exc.vaddr    = vaddr;
        @(negedge clk);
        exc.ex = 1'b0;
    endtask

    task automatic wait_interrupt();
        while (has_int !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    initial begin
        logic [13:0] regs [6];
        void'($urandom(40026));
        regs   = '{`CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3, `CSR_ERA, `CSR_EENTRY};
        reset  = 1'b1;
        access = '0;
        exc    = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Reset values
        csr_read(`CSR_CRMD);
        csr_read(`CSR_ECFG);
        csr_read(`CSR_TCFG);
        csr_read(`CSR_TVAL);

        // Masked writes and read-back
        foreach (regs[i]) begin
            csr_write(regs[i], '1, $urandom());
            repeat (5) begin
                csr_write(regs[i], $urandom(), $urandom());
                csr_read(regs[i]);
            end
        end
        csr_read(14'h3ff);

        // Exception entry from PLV 3 with IE set, fetch error then ALE
        csr_write(`CSR_CRMD, 32'h7, 32'h7);
        raise_exception(32'h1c00_1004, `ECODE_ADE, `ESUBCODE_ADEF, 32'hdead_0000);
        csr_read(`CSR_CRMD);
        csr_read(`CSR_PRMD);
        csr_read(`CSR_ERA);
        csr_read(`CSR_ESTAT);
        csr_read(`CSR_BADV);
        csr_write(`CSR_CRMD, 32'h7, 32'h7);
        raise_exception(32'h1c00_2010, `ECODE_ALE, 9'h000, 32'h0000_8003);
        csr_read(`CSR_BADV);
        csr_read(`CSR_ESTAT);

        // Return restores PLV and IE
        exc.ertn = 1'b1;
        @(negedge clk);
        exc.ertn = 1'b0;
        csr_read(`CSR_CRMD);

        // One-shot timer, initval 3
        csr_write(`CSR_ECFG, 32'h1fff, 32'h0800);
        csr_write(`CSR_TCFG, '1, {30'd3, 1'b0, 1'b1});
        wait_interrupt();
        repeat (4) csr_read(`CSR_TVAL);
        csr_write(`CSR_TICLR, 32'h1, 32'h1);
        csr_read(`CSR_ESTAT);

        // Periodic timer, initval 2, then LIE masked off
        csr_write(`CSR_TCFG, '1, {30'd2, 1'b1, 1'b1});
        repeat (3) begin
            wait_interrupt();
            csr_write(`CSR_TICLR, 32'h1, 32'h1);
        end
        csr_write(`CSR_ECFG, 32'h0800, 32'h0);
        repeat (20) csr_read(`CSR_ESTAT);
        csr_write(`CSR_TCFG, 32'h1, 32'h0);
        csr_read(`CSR_TVAL);

        $display("Errors: rdata %0d, ex_entry %0d, ertn_entry %0d, has_int %0d",
                 err_cnt[0], err_cnt[1], err_cnt[2], err_cnt[3]);
        if (err_cnt[0] + err_cnt[1] + err_cnt[2] + err_cnt[3] == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

endmodule

//--- logic/loong_csr.sv
`include "csr_macros.svh"

module loong_csr import csr_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  csr_access_t            access,
    input  exc_report_t            exc,
    output logic [`CSR_DATA_W-1:0] rdata,
    output logic [`CSR_DATA_W-1:0] ex_entry,
    output logic [`CSR_DATA_W-1:0] ertn_entry,
    output logic                   has_int
);

    localparam int SAVE_N = `CSR_SAVE3 - `CSR_SAVE0 + 1;

    csr_sel_t                          sel;
    exc_words_t                        exc_words;
    timer_words_t                      timer_words;
    logic [SAVE_N-1:0][`CSR_DATA_W-1:0] save_words;
    logic                              timer_pending;

    csr_decode u_decode (
        .clk         (clk),
        .reset       (reset),
        .access      (access),
        .exc_words   (exc_words),
        .timer_words (timer_words),
        .save_words  (save_words),
        .sel         (sel),
        .rdata       (rdata)
    );

    csr_exc_state u_exc_state (
        .clk           (clk),
        .reset         (reset),
        .sel           (sel),
        .wmask         (access.wmask),
        .wvalue        (access.wvalue),
        .exc           (exc),
        .timer_pending (timer_pending),
        .words         (exc_words),
        .ex_entry      (ex_entry),
        .ertn_entry    (ertn_entry),
        .has_int       (has_int)
    );

    csr_timer u_timer (
        .clk           (clk),
        .reset         (reset),
        .sel           (sel),
        .wmask         (access.wmask),
        .wvalue        (access.wvalue),
        .words         (timer_words),
        .timer_pending (timer_pending)
    );

    csr_save_bank #(
        .SAVE_COUNT (SAVE_N)
    ) u_save_bank (
        .clk    (clk),
        .sel    (sel),
        .wmask  (access.wmask),
        .wvalue (access.wvalue),
        .words  (save_words)
    );

endmodule

//--- logic/csr_save_bank.sv
`include "csr_macros.svh"

module csr_save_bank import csr_pkg::*; #(
    parameter int SAVE_COUNT = 4
) (
    input  logic                                    clk,
    input  csr_sel_t                                sel,
    input  logic [`CSR_DATA_W-1:0]                  wmask,
    input  logic [`CSR_DATA_W-1:0]                  wvalue,
    output logic [SAVE_COUNT-1:0][`CSR_DATA_W-1:0]  words
);

    logic [SAVE_COUNT-1:0] we;

    // Strobe i belongs to register number CSR_SAVE0 + i
    always_comb begin
        for (int i = 0; i < SAVE_COUNT; i++) begin
            we[i] = sel.save[i];
        end
    end

    // Scratch storage for software
    always_ff @(posedge clk) begin
        for (int i = 0; i < SAVE_COUNT; i++) begin
            if (we[i]) begin
                words[i] <= csr_merge(words[i], wmask, wvalue);
            end
        end
    end

endmodule

//--- logic/csr_timer.sv
`include "csr_macros.svh"

module csr_timer import csr_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  csr_sel_t               sel,
    input  logic [`CSR_DATA_W-1:0] wmask,
    input  logic [`CSR_DATA_W-1:0] wvalue,
    output timer_words_t           words,
    output logic                   timer_pending
);

    logic                   tcfg_en;
    logic                   tcfg_periodic;
    logic [29:0]            tcfg_initval;
    logic [`CSR_DATA_W-1:0] tcfg_word;
    logic [`CSR_DATA_W-1:0] tcfg_next;
    logic [`CSR_DATA_W-1:0] load_value;
    logic [`CSR_DATA_W-1:0] reload_value;
    logic [`CSR_DATA_W-1:0] cnt;
    logic                   cnt_zero;
    logic                   ticlr_hit;

    assign tcfg_word = {tcfg_initval, tcfg_periodic, tcfg_en};

    // Value TCFG takes after this cycle's write, decides the load
    assign tcfg_next    = csr_merge(tcfg_word, wmask, wvalue);
    assign load_value   = {tcfg_next[`TCFG_INITV], {`TIMER_SHIFT{1'b0}}};
    assign reload_value = {tcfg_initval, {`TIMER_SHIFT{1'b0}}};

    assign cnt_zero  = cnt == '0;
    assign ticlr_hit = sel.ticlr && wmask[`TICLR_CLR] && wvalue[`TICLR_CLR];

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= 30'b0;
        end else if (sel.tcfg) begin
            tcfg_en       <= tcfg_next[`TCFG_EN];
            tcfg_periodic <= tcfg_next[`TCFG_PERIODIC];
            tcfg_initval  <= tcfg_next[`TCFG_INITV];
        end
    end

    // One-shot wraps from zero to all ones and parks there
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt <= '1;
        end else if (sel.tcfg && tcfg_next[`TCFG_EN]) begin
            cnt <= load_value;
        end else if (tcfg_en && cnt != '1) begin
            if (cnt_zero && tcfg_periodic) begin
                cnt <= reload_value;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // Set has priority over a clear in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_pending <= 1'b0;
        end else if (tcfg_en && cnt_zero) begin
            timer_pending <= 1'b1;
        end else if (ticlr_hit) begin
            timer_pending <= 1'b0;
        end
    end

    assign words.tcfg  = tcfg_word;
    assign words.tval  = cnt;
    assign words.ticlr = '0;

    a_hold_when_off: assert property (@(posedge clk) disable iff (reset)
        !tcfg_en && !sel.tcfg |=> $stable(cnt));

endmodule

//--- logic/csr_exc_state.sv
`include "csr_macros.svh"

module csr_exc_state import csr_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  csr_sel_t               sel,
    input  logic [`CSR_DATA_W-1:0] wmask,
    input  logic [`CSR_DATA_W-1:0] wvalue,
    input  exc_report_t            exc,
    input  logic                   timer_pending,
    output exc_words_t             words,
    output logic [`CSR_DATA_W-1:0] ex_entry,
    output logic [`CSR_DATA_W-1:0] ertn_entry,
    output logic                   has_int
);

    logic [1:0]             crmd_plv;
    logic                   crmd_ie;
    logic [1:0]             prmd_pplv;
    logic                   prmd_pie;
    logic [1:0]             estat_sw;
    logic [5:0]             estat_ecode;
    logic [8:0]             estat_esubcode;
    logic [12:0]            estat_is;
    logic [`CSR_DATA_W-1:0] era;
    logic [25:0]            eentry_va;
    logic [`CSR_DATA_W-1:0] badv;
    logic [12:0]            ecfg_lie;
    logic                   addr_err;
    exc_words_t             wr;

    // Merged write values per register
    always_comb begin
        wr.crmd   = csr_merge(words.crmd, wmask, wvalue);
        wr.prmd   = csr_merge(words.prmd, wmask, wvalue);
        wr.estat  = csr_merge(words.estat, wmask, wvalue);
        wr.era    = csr_merge(words.era, wmask, wvalue);
        wr.eentry = csr_merge(words.eentry, wmask, wvalue);
        wr.badv   = csr_merge(words.badv, wmask, wvalue);
        wr.ecfg   = csr_merge(words.ecfg, wmask, wvalue);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv <= 2'b0;
            crmd_ie  <= 1'b0;
        end else if (exc.ex) begin
            crmd_plv <= 2'b0;
            crmd_ie  <= 1'b0;
        end else if (exc.ertn) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (sel.crmd) begin
            crmd_plv <= wr.crmd[`CRMD_PLV];
            crmd_ie  <= wr.crmd[`CRMD_IE];
        end
    end

    always_ff @(posedge clk) begin
        if (exc.ex) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (sel.prmd) begin
            prmd_pplv <= wr.prmd[`PRMD_PPLV];
            prmd_pie  <= wr.prmd[`PRMD_PIE];
        end
    end

    // Software interrupt bits are the only writable part of ESTAT
    always_ff @(posedge clk) begin
        if (reset) begin
            estat_sw <= 2'b0;
        end else if (sel.estat) begin
            estat_sw <= wr.estat[`ESTAT_IS10];
        end
    end

    always_ff @(posedge clk) begin
        if (exc.ex) begin
            estat_ecode    <= exc.ecode;
            estat_esubcode <= exc.esubcode;
            era            <= exc.pc;
        end else if (sel.era) begin
            era <= wr.era;
        end
    end

    assign addr_err = exc.ecode == `ECODE_ADE || exc.ecode == `ECODE_ALE;

    // Fetch error reports pc, data errors report the access address
    always_ff @(posedge clk) begin
        if (exc.ex && addr_err) begin
            badv <= (exc.ecode == `ECODE_ADE && exc.esubcode == `ESUBCODE_ADEF) ?
                    exc.pc : exc.vaddr;
        end else if (sel.badv) begin
            badv <= wr.badv;
        end
    end

    always_ff @(posedge clk) begin
        if (sel.eentry) begin
            eentry_va <= wr.eentry[`EENTRY_VA];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg_lie <= 13'b0;
        end else if (sel.ecfg) begin
            ecfg_lie <= wr.ecfg[`ECFG_LIE];
        end
    end

    always_comb begin
        estat_is                = 13'b0;
        estat_is[`ESTAT_IS10]   = estat_sw;
        estat_is[`IS_TIMER_BIT] = timer_pending;
    end

    always_comb begin
        words                    = '0;
        words.crmd[`CRMD_PLV]    = crmd_plv;
        words.crmd[`CRMD_IE]     = crmd_ie;
        words.prmd[`PRMD_PPLV]   = prmd_pplv;
        words.prmd[`PRMD_PIE]    = prmd_pie;
        words.estat              = {1'b0, estat_esubcode, estat_ecode, 3'b0, estat_is};
        words.era                = era;
        words.eentry[`EENTRY_VA] = eentry_va;
        words.badv               = badv;
        words.ecfg[`ECFG_LIE]    = ecfg_lie;
    end

    assign ex_entry   = words.eentry;
    assign ertn_entry = words.era;
    assign has_int    = (|(words.estat[11:0] & words.ecfg[11:0])) && crmd_ie;

    // Writeback never reports an exception and a return together
    a_ex_ertn_excl: assert property (@(posedge clk) disable iff (reset) !(exc.ex && exc.ertn));

endmodule

//--- logic/csr_decode.sv
`include "csr_macros.svh"

module csr_decode import csr_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  csr_access_t            access,
    input  exc_words_t             exc_words,
    input  timer_words_t           timer_words,
    input  logic [`CSR_SAVE3-`CSR_SAVE0:0][`CSR_DATA_W-1:0] save_words,
    output csr_sel_t               sel,
    output logic [`CSR_DATA_W-1:0] rdata
);

    localparam int SAVE_N = `CSR_SAVE3 - `CSR_SAVE0 + 1;

    logic              hit_crmd;
    logic              hit_prmd;
    logic              hit_estat;
    logic              hit_era;
    logic              hit_eentry;
    logic              hit_badv;
    logic              hit_ecfg;
    logic              hit_tcfg;
    logic              hit_tval;
    logic              hit_ticlr;
    logic [SAVE_N-1:0] hit_save;

    // Single compare per register, shared by write and read
    always_comb begin
        hit_crmd   = access.num == `CSR_CRMD;
        hit_prmd   = access.num == `CSR_PRMD;
        hit_estat  = access.num == `CSR_ESTAT;
        hit_era    = access.num == `CSR_ERA;
        hit_eentry = access.num == `CSR_EENTRY;
        hit_badv   = access.num == `CSR_BADV;
        hit_ecfg   = access.num == `CSR_ECFG;
        hit_tcfg   = access.num == `CSR_TCFG;
        hit_tval   = access.num == `CSR_TVAL;
        hit_ticlr  = access.num == `CSR_TICLR;
        for (int i = 0; i < SAVE_N; i++) begin
            hit_save[i] = access.num == `CSR_NUM_W'(`CSR_SAVE0 + i);
        end
    end

    always_comb begin
        sel.crmd   = access.we & hit_crmd;
        sel.prmd   = access.we & hit_prmd;
        sel.estat  = access.we & hit_estat;
        sel.era    = access.we & hit_era;
        sel.eentry = access.we & hit_eentry;
        sel.badv   = access.we & hit_badv;
        sel.ecfg   = access.we & hit_ecfg;
        sel.save   = {SAVE_N{access.we}} & hit_save;
        sel.tcfg   = access.we & hit_tcfg;
        sel.tval   = access.we & hit_tval;
        sel.ticlr  = access.we & hit_ticlr;
    end

    // AND-OR read mux, unmapped numbers fall through to zero
    always_comb begin
        rdata = ({`CSR_DATA_W{hit_crmd}}   & exc_words.crmd)
              | ({`CSR_DATA_W{hit_prmd}}   & exc_words.prmd)
              | ({`CSR_DATA_W{hit_estat}}  & exc_words.estat)
              | ({`CSR_DATA_W{hit_era}}    & exc_words.era)
              | ({`CSR_DATA_W{hit_eentry}} & exc_words.eentry)
              | ({`CSR_DATA_W{hit_badv}}   & exc_words.badv)
              | ({`CSR_DATA_W{hit_ecfg}}   & exc_words.ecfg)
              | ({`CSR_DATA_W{hit_tcfg}}   & timer_words.tcfg)
              | ({`CSR_DATA_W{hit_tval}}   & timer_words.tval)
              | ({`CSR_DATA_W{hit_ticlr}}  & timer_words.ticlr);
        for (int i = 0; i < SAVE_N; i++) begin
            rdata = rdata | ({`CSR_DATA_W{hit_save[i]}} & save_words[i]);
        end
    end

    // At most one register written per cycle
    a_sel_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(sel));

endmodule

//--- logic/csr_pkg.sv
`include "csr_macros.svh"

package csr_pkg;

    // Access from writeback, number also addresses the read
    typedef struct packed {
        logic                   we;
        logic [`CSR_NUM_W-1:0]  num;
        logic [`CSR_DATA_W-1:0] wmask;
        logic [`CSR_DATA_W-1:0] wvalue;
    } csr_access_t;

    typedef struct packed {
        logic                   ex;
        logic                   ertn;
        logic [`CSR_DATA_W-1:0] pc;
        logic [5:0]             ecode;
        logic [8:0]             esubcode;
        logic [`CSR_DATA_W-1:0] vaddr;
    } exc_report_t;

    // One write strobe per register
    typedef struct packed {
        logic                             crmd;
        logic                             prmd;
        logic                             estat;
        logic                             era;
        logic                             eentry;
        logic                             badv;
        logic                             ecfg;
        logic [`CSR_SAVE3-`CSR_SAVE0:0]   save;
        logic                             tcfg;
        logic                             tval;
        logic                             ticlr;
    } csr_sel_t;

    typedef struct packed {
        logic [`CSR_DATA_W-1:0] crmd;
        logic [`CSR_DATA_W-1:0] prmd;
        logic [`CSR_DATA_W-1:0] estat;
        logic [`CSR_DATA_W-1:0] era;
        logic [`CSR_DATA_W-1:0] eentry;
        logic [`CSR_DATA_W-1:0] badv;
        logic [`CSR_DATA_W-1:0] ecfg;
    } exc_words_t;

    typedef struct packed {
        logic [`CSR_DATA_W-1:0] tcfg;
        logic [`CSR_DATA_W-1:0] tval;
        logic [`CSR_DATA_W-1:0] ticlr;
    } timer_words_t;

    // Masked write: unmasked bits keep the old value
    function automatic logic [`CSR_DATA_W-1:0] csr_merge(
        input logic [`CSR_DATA_W-1:0] old,
        input logic [`CSR_DATA_W-1:0] mask,
        input logic [`CSR_DATA_W-1:0] value
    );
        return (old & ~mask) | (value & mask);
    endfunction

endpackage

//--- logic/csr_macros.svh
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

`define CSR_NUM_W       14
`define CSR_DATA_W      32

// Register numbers
`define CSR_CRMD        14'h000
`define CSR_PRMD        14'h001
`define CSR_ECFG        14'h004
`define CSR_ESTAT       14'h005
`define CSR_ERA         14'h006
`define CSR_BADV        14'h007
`define CSR_EENTRY      14'h00c
`define CSR_SAVE0       14'h030
`define CSR_SAVE1       14'h031
`define CSR_SAVE2       14'h032
`define CSR_SAVE3       14'h033
`define CSR_TCFG        14'h041
`define CSR_TVAL        14'h042
`define CSR_TICLR       14'h044

// Field positions
`define CRMD_PLV        1:0
`define CRMD_IE         2
`define PRMD_PPLV       1:0
`define PRMD_PIE        2
`define EENTRY_VA       31:6
`define ECFG_LIE        12:0
`define ESTAT_IS10      1:0
`define TCFG_EN         0
`define TCFG_PERIODIC   1
`define TCFG_INITV      31:2
`define TICLR_CLR       0

`define ECODE_ADE       6'h08
`define ECODE_ALE       6'h09
`define ESUBCODE_ADEF   9'h000

`define IS_TIMER_BIT    11
// Counter runs at four ticks per initval step
`define TIMER_SHIFT     2

`endif
